//--- rtl/fib_datapath_defines.svh
`ifndef FIB_DATAPATH_DEFINES_SVH
`define FIB_DATAPATH_DEFINES_SVH

// Datapath width shared by the register file, ALU and result beat
`define DATA_W 16

// Register file geometry
`define NUM_REGS 16
`define REG_ADDR_W 4

// Width of the ALU opcode field in the control word
`define OPCODE_W 5

`endif

//--- rtl/alu_pkg.sv
`include "fib_datapath_defines.svh"

package alu_pkg;

	// Only op_add is used by the Fibonacci sequence
	typedef enum logic [`OPCODE_W-1:0] {
		op_and = 5'b00001,
		op_or  = 5'b00010,
		op_xor = 5'b00011,
		op_add = 5'b00101, // Fixed add encoding of the control word
		op_sub = 5'b01001
	} alu_op_t;

	typedef struct packed {
		logic carry;    // Carry out or borrow for op_sub
		logic zero;
		logic negative; // Sign bit of the result
		logic overflow; // Signed overflow
	} alu_flags_t;

endpackage

//--- rtl/ctrl_pkg.sv
`include "fib_datapath_defines.svh"

package ctrl_pkg;

	import alu_pkg::*;

	// One sequencer step for register file, operand mux and ALU
	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rs; // First operand register
		logic [`REG_ADDR_W-1:0] rd; // Second operand register
		logic [`NUM_REGS-1:0]   re; // One-hot write enable set only on transfer
		alu_op_t                opcode;
		logic [`DATA_W-1:0]     imm;
		logic                   ri; // Use imm instead of rd read
		logic                   fe; // Load the flag register
	} ctrl_word_t;

	// One register write as seen outside the datapath
	typedef struct packed {
		logic [`REG_ADDR_W-1:0] dest;
		logic [`DATA_W-1:0]     value;
		alu_flags_t             flags;
	} result_beat_t;

endpackage

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`include "fib_datapath_defines.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`NUM_REGS-1:0]   re,
	input  logic [`DATA_W-1:0]     wdata,
	input  logic [`REG_ADDR_W-1:0] rs,
	input  logic [`REG_ADDR_W-1:0] rd,
	output logic [`DATA_W-1:0]     rs_data,
	output logic [`DATA_W-1:0]     rd_data
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			// R0 is never written
			for (int i = 1; i < `NUM_REGS; i++)
			begin
				if (re[i])
				begin
					regs[i] <= wdata;
				end
			end
		end
	end

	assign rs_data = (rs == '0) ? '0 : regs[rs]; // R0 is constant zero
	assign rd_data = (rd == '0) ? '0 : regs[rd];

endmodule

//--- rtl/alu.sv
`timescale 1ns/10ps
`include "fib_datapath_defines.svh"

module alu (
	input  logic                clk,
	input  logic                rst,
	input  logic [`DATA_W-1:0]  a,
	input  logic [`DATA_W-1:0]  b,
	input  alu_pkg::alu_op_t    opcode,
	input  logic                fe,
	output logic [`DATA_W-1:0]  result,
	output alu_pkg::alu_flags_t next_flags,
	output alu_pkg::alu_flags_t flags
);

	import alu_pkg::*;

	logic [`DATA_W:0] sum_ext; // One extra bit for carry or borrow
	logic             carry;
	logic             overflow;

	always_comb
	begin
		sum_ext  = '0;
		carry    = 1'b0;
		overflow = 1'b0;
		case (opcode)
			op_add:
			begin
				sum_ext  = {1'b0, a} + {1'b0, b};
				carry    = sum_ext[`DATA_W];
				// Same operand signs but result sign differs
				overflow = (a[`DATA_W-1] == b[`DATA_W-1]) &&
					(sum_ext[`DATA_W-1] != a[`DATA_W-1]);
			end
			op_sub:
			begin
				sum_ext  = {1'b0, a} - {1'b0, b};
				carry    = sum_ext[`DATA_W]; // Borrow
				overflow = (a[`DATA_W-1] != b[`DATA_W-1]) &&
					(sum_ext[`DATA_W-1] != a[`DATA_W-1]);
			end
			op_and:
			begin
				sum_ext = {1'b0, a & b};
			end
			op_or:
			begin
				sum_ext = {1'b0, a | b};
			end
			op_xor:
			begin
				sum_ext = {1'b0, a ^ b};
			end
			default:
			begin
				sum_ext = '0; // Undefined opcode yields zero
			end
		endcase
	end

	assign result = sum_ext[`DATA_W-1:0];

	always_comb
	begin
		next_flags.carry    = carry;
		next_flags.zero     = (result == '0);
		next_flags.negative = result[`DATA_W-1];
		next_flags.overflow = overflow;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			flags <= '0;
		end
		else if (fe)
		begin
			flags <= next_flags; // Only on steps that update flags
		end
	end

endmodule

//--- rtl/fib_ctrl_fsm.sv
`timescale 1ns/10ps
`include "fib_datapath_defines.svh"

module fib_ctrl_fsm (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 res_ready,
	output ctrl_pkg::ctrl_word_t ctrl,
	output logic                 res_valid,
	output logic                 busy,
	output logic                 done
);

	import alu_pkg::*;

	// Step k writes R(k+1), so the last step writes the top register
	localparam logic [`REG_ADDR_W-1:0] last_step = `REG_ADDR_W'(`NUM_REGS - 2);
	localparam logic [`DATA_W-1:0]     seed_imm  = `DATA_W'(1);

	typedef enum logic [1:0] {
		st_idle,
		st_step,
		st_done
	} state_t;

	state_t                 state;
	logic [`REG_ADDR_W-1:0] step;  // Current step while in st_step
	logic [`REG_ADDR_W-1:0] dest;
	logic                   xfer;

	assign res_valid = (state == st_step);
	assign busy      = (state == st_step);
	assign done      = (state == st_done);
	assign xfer      = res_valid & res_ready; // Beat accepted this cycle
	assign dest      = step + `REG_ADDR_W'(1);

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= st_idle;
			step  <= '0;
		end
		else
		begin
			case (state)
				st_idle, st_done:
				begin
					if (start) // Start is ignored while stepping
					begin
						state <= st_step;
						step  <= '0;
					end
				end
				st_step:
				begin
					// Hold under back-pressure so no beat is lost or repeated
					if (xfer)
					begin
						if (step == last_step)
						begin
							state <= st_done;
						end
						else
						begin
							step <= step + `REG_ADDR_W'(1);
						end
					end
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_comb
	begin
		ctrl        = '0;
		ctrl.opcode = op_add;
		ctrl.rd     = step;
		if (step == '0)
		begin
			// R1 <- R0 + 1 with the flag register left alone
			ctrl.rs  = '0;
			ctrl.imm = seed_imm;
			ctrl.ri  = 1'b1;
		end
		else
		begin
			// R(k+1) <- R(k-1) + R(k)
			ctrl.rs = step - `REG_ADDR_W'(1);
			ctrl.fe = xfer; // Flags load together with the write
		end
		if (xfer)
		begin
			ctrl.re[dest] = 1'b1;
		end
	end

endmodule

//--- rtl/fib_datapath.sv
`timescale 1ns/10ps
`include "fib_datapath_defines.svh"

module fib_datapath (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic                   res_ready,
	output logic                   res_valid,
	output ctrl_pkg::result_beat_t res,
	output logic                   busy,
	output logic                   done,
	output alu_pkg::alu_flags_t    flags
);

	import alu_pkg::*;
	import ctrl_pkg::*;

	ctrl_word_t         ctrl;
	logic [`DATA_W-1:0] rs_data;
	logic [`DATA_W-1:0] rd_data;
	logic [`DATA_W-1:0] operand_b;
	logic [`DATA_W-1:0] alu_result;
	alu_flags_t         next_flags;

	fib_ctrl_fsm u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.res_ready (res_ready),
		.ctrl      (ctrl),
		.res_valid (res_valid),
		.busy      (busy),
		.done      (done)
	);

	reg_file u_regs (
		.clk     (clk),
		.rst     (rst),
		.re      (ctrl.re),
		.wdata   (alu_result),
		.rs      (ctrl.rs),
		.rd      (ctrl.rd),
		.rs_data (rs_data),
		.rd_data (rd_data)
	);

	assign operand_b = ctrl.ri ? ctrl.imm : rd_data; // Immediate mux

	alu u_alu (
		.clk        (clk),
		.rst        (rst),
		.a          (rs_data),
		.b          (operand_b),
		.opcode     (ctrl.opcode),
		.fe         (ctrl.fe),
		.result     (alu_result),
		.next_flags (next_flags),
		.flags      (flags)
	);

	// Each step writes the register right after its second source
	assign res.dest  = ctrl.rd + `REG_ADDR_W'(1);
	assign res.value = alu_result;
	assign res.flags = next_flags;

endmodule

//--- testbench/fib_datapath_checker.sv
`timescale 1ns/10ps
`include "fib_datapath_defines.svh"

module fib_datapath_checker (
	input logic                   clk,
	input logic                   rst,
	input logic                   res_valid,
	input logic                   res_ready,
	input ctrl_pkg::result_beat_t res,
	input logic [`NUM_REGS-1:0]   re
);

	// A stalled beat must be offered again unchanged
	held_beat: assert property (@(posedge clk) disable iff (!rst)
		(res_valid && !res_ready) |=> $stable(res))
		else $error("res changed while res_valid was high and res_ready low");

	valid_in_reset: assert property (@(posedge clk)
		!rst |=> !res_valid)
		else $error("res_valid high after a reset cycle");

	// Each accepted beat writes exactly one register
	single_write: assert property (@(posedge clk) disable iff (!rst)
		(res_valid && res_ready) |-> $onehot(re))
		else $error("register write enable not one-hot on a transfer");

endmodule

bind fib_datapath fib_datapath_checker u_checker (
	.clk       (clk),
	.rst       (rst),
	.res_valid (res_valid),
	.res_ready (res_ready),
	.res       (res),
	.re        (ctrl.re)
);

//--- testbench/fib_datapath_tb.sv
`timescale 1ns/10ps
`include "fib_datapath_defines.svh"

module fib_datapath_tb;

	import alu_pkg::*;
	import ctrl_pkg::*;

	localparam int beat_count = `NUM_REGS - 1;
	localparam int max_cycles = 200; // Cycle limit per sequence

	logic         clk = 1'b0;
	logic         rst;
	logic         start;
	logic         res_ready;
	logic         res_valid;
	result_beat_t res;
	logic         busy;
	logic         done;
	alu_flags_t   flags;

	logic [`DATA_W-1:0] model_fib [$]; // Index n holds the value expected in Rn
	alu_flags_t         exp_flags;     // Expected content of the flag register
	int                 seed = 32'hae2d;
	int                 value_errors = 0;
	int                 timeout_errors = 0;

	fib_datapath DUT (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.res_ready (res_ready),
		.res_valid (res_valid),
		.res       (res),
		.busy      (busy),
		.done      (done),
		.flags     (flags)
	);

	always #4 clk = ~clk;

	task automatic report_mismatch(input string what);
		$display("FAIL %0t: %s", $time, what);
		value_errors++;
	endtask

	// Flags of a 16-bit add from the unsigned and signed integer sums
	function automatic alu_flags_t add_flags(input logic [`DATA_W-1:0] a,
		input logic [`DATA_W-1:0] b);
		int         usum;
		int         ssum;
		int         wrapped;
		alu_flags_t f;
		usum       = int'(a) + int'(b);
		ssum       = int'($signed(a)) + int'($signed(b));
		wrapped    = usum % (1 << `DATA_W);
		f.carry    = (usum >= (1 << `DATA_W));
		f.zero     = (wrapped == 0);
		f.negative = (wrapped >= (1 << (`DATA_W - 1)));
		f.overflow = (ssum >= (1 << (`DATA_W - 1))) || (ssum < -(1 << (`DATA_W - 1)));
		return f;
	endfunction

	task automatic build_model;
		model_fib = {};
		model_fib.push_back('0);
		model_fib.push_back(`DATA_W'(1));
		for (int n = 2; n < `NUM_REGS; n++)
		begin
			model_fib.push_back(model_fib[n-1] + model_fib[n-2]);
		end
	endtask

	task automatic apply_reset;
		rst       <= 1'b0;
		start     <= 1'b0;
		res_ready <= 1'b0;
		exp_flags = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic check_idle_outputs;
		@(posedge clk);
		assert (!res_valid && !busy && !done)
			else report_mismatch($sformatf("after reset valid %b busy %b done %b",
				res_valid, busy, done));
		assert (flags == '0)
			else report_mismatch($sformatf("after reset flags %b", flags));
	endtask

	// Done holds with no further beats even with the sink ready
	task automatic check_quiet(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			res_ready <= 1'b1;
			start     <= 1'b0;
			@(posedge clk);
			assert (!res_valid && !busy && done)
				else report_mismatch($sformatf("after done valid %b busy %b done %b",
					res_valid, busy, done));
			assert (flags == exp_flags)
				else report_mismatch($sformatf("flags %b after done, expected %b",
					flags, exp_flags));
		end
	endtask

	// Runs one sequence from a single start and checks every beat
	// A nonzero poke_cycle pulses start again in the middle of the run
	task automatic run_sequence(input bit random_ready, input int poke_cycle);
		int                 beats;
		int                 cycles;
		int                 n;
		logic [31:0]        rnd;
		logic [`DATA_W-1:0] op_a;
		logic [`DATA_W-1:0] op_b;
		alu_flags_t         want;
		beats  = 0;
		cycles = 0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		rnd = $random(seed);
		res_ready <= random_ready ? rnd[0] : 1'b1;
		while (beats < beat_count && cycles < max_cycles)
		begin
			@(posedge clk);
			cycles++;
			assert (res_valid && busy && !done)
				else report_mismatch($sformatf("cycle %0d: valid %b busy %b done %b",
					cycles, res_valid, busy, done));
			assert (flags == exp_flags)
				else report_mismatch($sformatf("flags %b, expected %b", flags, exp_flags));
			if (res_valid && res_ready)
			begin
				n    = beats + 1;
				op_a = (n == 1) ? '0 : model_fib[n-2]; // R1 is R0 plus immediate 1
				op_b = (n == 1) ? `DATA_W'(1) : model_fib[n-1];
				want = add_flags(op_a, op_b);
				assert (res.dest == `REG_ADDR_W'(n) && res.value == model_fib[n])
					else report_mismatch($sformatf("beat %0d: R%0d = %0d, expected R%0d = %0d",
						n, res.dest, res.value, n, model_fib[n]));
				assert (res.flags == want)
					else report_mismatch($sformatf("beat %0d: flags %b, expected %b",
						n, res.flags, want));
				if (n >= 2)
				begin
					exp_flags = want; // Seed step leaves the flag register alone
				end
				beats++;
			end
			rnd = $random(seed);
			res_ready <= random_ready ? rnd[0] : 1'b1;
			start     <= (cycles == poke_cycle);
		end
		if (beats < beat_count)
		begin
			$display("Timeout: only %0d of %0d result beats arrived within %0d cycles",
				beats, beat_count, max_cycles);
			timeout_errors++;
		end
		else
		begin
			@(posedge clk);
			assert (done && !busy && !res_valid)
				else report_mismatch($sformatf("after last beat valid %b busy %b done %b",
					res_valid, busy, done));
			assert (flags == exp_flags)
				else report_mismatch($sformatf("final flags %b, expected %b",
					flags, exp_flags));
		end
	endtask

	initial
	begin
		apply_reset();
		build_model();
		check_idle_outputs();

		run_sequence(1'b0, 0); // Sink always ready
		check_quiet(4);
		run_sequence(1'b1, 0); // Random back-pressure
		check_quiet(4);
		run_sequence(1'b1, 3); // Extra start while busy
		check_quiet(4);
		run_sequence(1'b0, 0); // Restart after done
		check_quiet(4);

		$display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- fib_datapath.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/ctrl_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/fib_ctrl_fsm.sv
rtl/fib_datapath.sv
testbench/fib_datapath_checker.sv
testbench/fib_datapath_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the fib_datapath testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f fib_datapath.f \
	--top-module fib_datapath_tb \
	-o fib_datapath_sim

./obj_dir/fib_datapath_sim | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
